//--- common/row_walk_pkg.sv
//==========================================================================
// Types shared by the decode, counter and result stages
// Addresses are plain vectors, signed only where the result stage clamps
//==========================================================================

package row_walk_pkg;

	//==========================================================================
	// Data types
	//==========================================================================

	// Address, offset, bound or row index
	typedef logic [tau_cfg_pkg::GLOBAL_ADDR_BW-1:0] gaddr_t;

	// Pad code at a chunk edge
	typedef logic [tau_cfg_pkg::V_BW-1:0] pad_t;

	// One flag per walked dimension
	typedef logic [tau_cfg_pkg::ROW_DIM-1:0] dim_flags_t;

	//==========================================================================
	// State machines
	//==========================================================================

	// Command buffer
	// HOLD means a second command waits behind the active one
	typedef enum logic [1:0] {
		DEC_IDLE = 2'd0,
		DEC_HOLD = 2'd1,
		DEC_BUSY = 2'd2
	} decode_state_e;

	// Row walker
	typedef enum logic {
		WALK_IDLE = 1'b0,
		WALK_RUN  = 1'b1
	} walk_state_e;

endpackage

//--- common/tau_cfg_pkg.sv
//==========================================================================
// Fixed geometry for the row start generator
// DIM is the full chunk rank and the innermost dimension is the row itself
// Widths are project wide and no module overrides them
//==========================================================================

package tau_cfg_pkg;

	//==========================================================================
	// Chunk geometry
	//==========================================================================

	// Number of chunk dimensions, innermost one included
	localparam int DIM = 3;

	// Dimensions walked row by row
	localparam int ROW_DIM = DIM - 1;

	//==========================================================================
	// Widths
	//==========================================================================

	// Global address width, offsets and bounds share it
	localparam int GLOBAL_ADDR_BW = 16;

	// Elements per vector word
	localparam int VSIZE = 8;

	// Pad code selects a position inside one vector word
	localparam int V_BW = $clog2(VSIZE);

endpackage

//--- files.f
common/tau_cfg_pkg.sv
common/row_walk_pkg.sv
verilog/row_cmd_decode.sv
row_walk/row_counter.sv
row_walk/row_addr_clamp.sv
verilog/chunk_row_start.sv
verification/tb_clk_gen.sv
verification/chunk_row_start_props.sv
verification/chunk_row_start_tb.sv

//--- row_walk/row_addr_clamp.sv
//==========================================================================
// Row start address with edge clamp and pad selection
// Offsets and bounds come in address units, no scaling is done here
// One entry output register, refilled in the cycle it drains
//==========================================================================

`timescale 1ns/10ps

module row_addr_clamp (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  logic                     i_step_rdy,
	output logic                     o_step_ack,
	input  row_walk_pkg::gaddr_t     i_step_idx    [tau_cfg_pkg::ROW_DIM],
	input  row_walk_pkg::dim_flags_t i_step_at_end,
	input  logic                     i_step_islast,
	input  row_walk_pkg::gaddr_t     i_mofs        [tau_cfg_pkg::DIM],
	input  row_walk_pkg::gaddr_t     i_mbound      [tau_cfg_pkg::DIM],
	input  row_walk_pkg::pad_t       i_mpad        [tau_cfg_pkg::DIM],
	input  row_walk_pkg::gaddr_t     i_maddr,
	output logic                     o_row_rdy,
	input  logic                     i_row_ack,
	output row_walk_pkg::gaddr_t     o_row_linear,
	output logic                     o_row_islast,
	output row_walk_pkg::pad_t       o_row_pad
);

	//==========================================================================
	// Internal signals
	//==========================================================================

	row_walk_pkg::gaddr_t row_sum   [tau_cfg_pkg::ROW_DIM];
	row_walk_pkg::gaddr_t row_clamp [tau_cfg_pkg::ROW_DIM];
	row_walk_pkg::gaddr_t linear_nxt;
	row_walk_pkg::pad_t   pad_nxt;
	logic row_valid;
	logic step_xfer;

	//==========================================================================
	// Clamp and linearize
	//==========================================================================

	// Per dimension
	// negative sum clamps to zero
	// sum at or past the bound clamps to the last full row start
	always_comb begin
		linear_nxt = i_maddr;
		for (int i = 0; i < tau_cfg_pkg::ROW_DIM; i++) begin
			row_sum[i] = i_step_idx[i] + i_mofs[i];
			if (row_sum[i][tau_cfg_pkg::GLOBAL_ADDR_BW-1]) begin
				row_clamp[i] = '0;
			end else if ($signed(row_sum[i]) >= $signed(i_mbound[i])) begin
				row_clamp[i] = i_mbound[i] - i_mbound[i+1];
			end else begin
				row_clamp[i] = row_sum[i];
			end
			// Accumulate into the base address
			linear_nxt = linear_nxt + row_clamp[i];
		end
	end

	//==========================================================================
	// Pad select
	//==========================================================================

	// OR of pads over dimensions sitting at their end
	// Routing is reversed, walked dimension i picks mpad[DIM-1-i]
	always_comb begin
		pad_nxt = '0;
		for (int i = 0; i < tau_cfg_pkg::ROW_DIM; i++) begin
			if (i_step_at_end[i]) begin
				pad_nxt = pad_nxt | i_mpad[tau_cfg_pkg::DIM-1-i];
			end
		end
	end

	//==========================================================================
	// Output register
	//==========================================================================

	// Take a step when empty or when the current row leaves this cycle
	assign o_step_ack = !row_valid || i_row_ack;
	assign step_xfer = i_step_rdy && o_step_ack;
	assign o_row_rdy = row_valid;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			row_valid <= 1'b0;
		end else if (step_xfer) begin
			row_valid <= 1'b1;
		end else if (i_row_ack) begin
			row_valid <= 1'b0;
		end
	end

	// Row data holds while the sink stalls
	always_ff @(posedge i_clk) begin
		if (step_xfer) begin
			o_row_linear <= linear_nxt;
			o_row_islast <= i_step_islast;
			o_row_pad <= pad_nxt;
		end
	end

endmodule

//--- row_walk/row_counter.sv
//==========================================================================
// Nested row counters over the walked dimensions
// Each end must be a multiple of its stride and every stride nonzero
// Job fields are read live, the job port holds them until the ack
//==========================================================================

`timescale 1ns/10ps

module row_counter (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  logic                     i_job_rdy,
	output logic                     o_job_ack,
	input  row_walk_pkg::gaddr_t     i_job_end    [tau_cfg_pkg::ROW_DIM],
	input  row_walk_pkg::gaddr_t     i_job_stride [tau_cfg_pkg::ROW_DIM],
	output logic                     o_step_rdy,
	input  logic                     i_step_ack,
	output row_walk_pkg::gaddr_t     o_step_idx   [tau_cfg_pkg::ROW_DIM],
	output row_walk_pkg::dim_flags_t o_step_at_end,
	output logic                     o_step_islast
);

	//==========================================================================
	// Internal signals
	//==========================================================================

	row_walk_pkg::walk_state_e state;
	logic job_done;
	logic job_start;
	logic step_xfer;
	logic carry;
	row_walk_pkg::gaddr_t idx_nxt [tau_cfg_pkg::ROW_DIM];

	assign o_step_rdy = (state == row_walk_pkg::WALK_RUN);
	assign step_xfer = o_step_rdy && i_step_ack;

	// Pulse one cycle after the last step
	assign o_job_ack = job_done;

	// Same job is still offered during the ack cycle, so skip it
	assign job_start = (state == row_walk_pkg::WALK_IDLE) && i_job_rdy && !job_done;

	//==========================================================================
	// Edge flags
	//==========================================================================

	always_comb begin
		for (int i = 0; i < tau_cfg_pkg::ROW_DIM; i++) begin
			o_step_at_end[i] = (o_step_idx[i] == i_job_end[i]);
		end
	end

	// Last row once every walked dimension sits at its end
	assign o_step_islast = &o_step_at_end;

	//==========================================================================
	// Next index
	//==========================================================================

	// Carry ripples from the innermost walked dimension outward
	// A dimension at its end wraps to zero and passes the carry on
	always_comb begin
		carry = 1'b1;
		for (int i = tau_cfg_pkg::ROW_DIM - 1; i >= 0; i--) begin
			if (!carry) begin
				idx_nxt[i] = o_step_idx[i];
			end else if (o_step_at_end[i]) begin
				idx_nxt[i] = '0;
			end else begin
				idx_nxt[i] = o_step_idx[i] + i_job_stride[i];
				carry = 1'b0;
			end
		end
	end

	//==========================================================================
	// Walk FSM
	//==========================================================================

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= row_walk_pkg::WALK_IDLE;
			job_done <= 1'b0;
			for (int i = 0; i < tau_cfg_pkg::ROW_DIM; i++) begin
				o_step_idx[i] <= '0;
			end
		end else begin
			job_done <= 1'b0;
			case (state)
				row_walk_pkg::WALK_IDLE: begin
					if (job_start) begin
						state <= row_walk_pkg::WALK_RUN;
						for (int i = 0; i < tau_cfg_pkg::ROW_DIM; i++) begin
							o_step_idx[i] <= '0;
						end
					end
				end
				row_walk_pkg::WALK_RUN: begin
					// Stall while the result stage holds off
					if (step_xfer) begin
						if (o_step_islast) begin
							state <= row_walk_pkg::WALK_IDLE;
							job_done <= 1'b1;
						end else begin
							o_step_idx <= idx_nxt;
						end
					end
				end
				default: state <= row_walk_pkg::WALK_IDLE;
			endcase
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the row start generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module chunk_row_start_tb \
	-f files.f \
	-o sim_chunk_row_start > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status, see $BUILD_LOG"
	exit 1
fi

./obj_dir/sim_chunk_row_start > "$SIM_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status, see $SIM_LOG"
	exit 1
fi

if grep -q "SOME TESTS FAILED" "$SIM_LOG"; then
	echo "Simulation reported failures, see $SIM_LOG"
	exit 1
fi

if ! grep -q "ALL TESTS PASSED" "$SIM_LOG"; then
	echo "Simulation ended without a result, see $SIM_LOG"
	exit 1
fi

echo "Simulation passed"
exit 0

//--- verification/chunk_row_start_props.sv
//==========================================================================
// Handshake and reset properties, bound into the top level
// Slot occupancy is counted from the command and job handshakes
//==========================================================================

`timescale 1ns/10ps

module chunk_row_start_props (
	input logic                 i_clk,
	input logic                 i_rst_n,
	input logic                 i_cmd_rdy,
	input logic                 i_cmd_ack,
	input logic                 i_job_rdy,
	input logic                 i_job_ack,
	input logic                 i_row_rdy,
	input logic                 i_row_ack,
	input row_walk_pkg::gaddr_t i_row_linear,
	input logic                 i_row_islast,
	input row_walk_pkg::pad_t   i_row_pad
);

	// Commands accepted minus jobs released by the walker
	logic [1:0] slots;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			slots <= 2'd0;
		end else begin
			slots <= slots + {1'b0, i_cmd_rdy && i_cmd_ack}
				- {1'b0, i_job_rdy && i_job_ack};
		end
	end

	// No row offered while reset is active
	row_rdy_in_reset: assert property (@(posedge i_clk) !i_rst_n |-> !i_row_rdy)
		else $error("o_row_rdy high during reset");

	// Stalled row keeps rdy and all of its data
	row_hold_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_row_rdy && !i_row_ack) |=> (i_row_rdy && $stable(i_row_linear)
		&& $stable(i_row_islast) && $stable(i_row_pad)))
		else $error("row output changed while stalled");

	// Two commands in the buffer leave no room for a third
	cmd_ack_when_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(slots == 2'd2) |-> !i_cmd_ack)
		else $error("o_cmd_ack high with both command slots full");

endmodule

bind chunk_row_start chunk_row_start_props chunk_row_start_props_inst (
	.i_clk        (i_clk),
	.i_rst_n      (i_rst_n),
	.i_cmd_rdy    (i_cmd_rdy),
	.i_cmd_ack    (o_cmd_ack),
	.i_job_rdy    (job_rdy),
	.i_job_ack    (job_ack),
	.i_row_rdy    (o_row_rdy),
	.i_row_ack    (i_row_ack),
	.i_row_linear (o_row_linear),
	.i_row_islast (o_row_islast),
	.i_row_pad    (o_row_pad)
);

//--- verification/chunk_row_start_tb.sv
//==========================================================================
// Table driven testbench for the row start generator
// Commands are sent back to back, row ack is random with a fixed seed
// Each end must be a multiple of its stride, as the walker requires
//==========================================================================

`timescale 1ns/10ps

module chunk_row_start_tb;

	logic clk, rst_n;
	logic cmd_rdy, cmd_ack, row_rdy, row_ack, row_islast;
	row_walk_pkg::gaddr_t mofs [tau_cfg_pkg::DIM];
	row_walk_pkg::pad_t mpad [tau_cfg_pkg::DIM];
	row_walk_pkg::gaddr_t mbound [tau_cfg_pkg::DIM];
	row_walk_pkg::gaddr_t mlast [tau_cfg_pkg::DIM];
	row_walk_pkg::gaddr_t maddr, row_linear;
	row_walk_pkg::pad_t row_pad;

	// Command table, up to 8 entries
	row_walk_pkg::gaddr_t tbl_mofs [8][tau_cfg_pkg::DIM];
	row_walk_pkg::pad_t tbl_mpad [8][tau_cfg_pkg::DIM];
	row_walk_pkg::gaddr_t tbl_mbound [8][tau_cfg_pkg::DIM];
	row_walk_pkg::gaddr_t tbl_mlast [8][tau_cfg_pkg::DIM];
	row_walk_pkg::gaddr_t tbl_maddr [8];
	int cmd_rows [8];
	int cum_rows [8];

	// Expected rows in output order
	row_walk_pkg::gaddr_t exp_linear [$];
	row_walk_pkg::pad_t exp_pad [$];
	bit exp_last [$];

	int n_cmds = 0, total_rows = 0, rows_seen = 0, out_cmd = 0, run_len = 0;
	int errors = 0, checks = 0, cycle_count = 0, cycle_limit = 0;
	int rand_val;
	integer seed = 78558;

	tb_clk_gen clk_gen_inst (.o_clk(clk), .o_rst_n(rst_n));

	chunk_row_start chunk_row_start_inst (
		.i_clk        (clk),
		.i_rst_n      (rst_n),
		.i_cmd_rdy    (cmd_rdy),
		.o_cmd_ack    (cmd_ack),
		.i_mofs       (mofs),
		.i_mpad       (mpad),
		.i_mbound     (mbound),
		.i_mlast      (mlast),
		.i_maddr      (maddr),
		.o_row_rdy    (row_rdy),
		.i_row_ack    (row_ack),
		.o_row_linear (row_linear),
		.o_row_islast (row_islast),
		.o_row_pad    (row_pad)
	);

	//==========================================================================
	// Table and reference model
	//==========================================================================

	// Innermost pad mpad[0] is never routed, so it is kept at all ones
	task automatic add_cmd(input row_walk_pkg::gaddr_t addr, ofs0, ofs1,
		input row_walk_pkg::pad_t pad1, pad2,
		input row_walk_pkg::gaddr_t bnd0, bnd1, bnd2, last0, last1);
		tbl_maddr[n_cmds] = addr;
		tbl_mofs[n_cmds] = '{ofs0, ofs1, 16'h0000};
		tbl_mpad[n_cmds] = '{3'h7, pad1, pad2};
		tbl_mbound[n_cmds] = '{bnd0, bnd1, bnd2};
		tbl_mlast[n_cmds] = '{last0, last1, bnd2 - 16'd1};
		n_cmds++;
	endtask

	// Signed clamp of one walked dimension
	function automatic row_walk_pkg::gaddr_t clamp_dim(input row_walk_pkg::gaddr_t idx,
		input int k, input int d);
		row_walk_pkg::gaddr_t sum;
		sum = idx + tbl_mofs[k][d];
		if (sum[tau_cfg_pkg::GLOBAL_ADDR_BW-1])
			return '0;
		if ($signed(sum) >= $signed(tbl_mbound[k][d]))
			return tbl_mbound[k][d] - tbl_mbound[k][d+1];
		return sum;
	endfunction

	// Dimension 1 fastest, strides taken from the next bound
	task automatic build_expected(input int k);
		row_walk_pkg::gaddr_t i0, i1;
		row_walk_pkg::pad_t pad;
		bit at0, at1;
		i0 = '0;
		do begin
			i1 = '0;
			do begin
				at0 = (i0 == tbl_mlast[k][0]);
				at1 = (i1 == tbl_mlast[k][1]);
				pad = '0;
				if (at0)
					pad = pad | tbl_mpad[k][tau_cfg_pkg::DIM-1];
				if (at1)
					pad = pad | tbl_mpad[k][tau_cfg_pkg::DIM-2];
				exp_linear.push_back(tbl_maddr[k] + clamp_dim(i0, k, 0) + clamp_dim(i1, k, 1));
				exp_pad.push_back(pad);
				exp_last.push_back(at0 && at1);
				i1 = i1 + tbl_mbound[k][2];
			end while (!at1);
			i0 = i0 + tbl_mbound[k][1];
		end while (!at0);
	endtask

	//==========================================================================
	// Checks
	//==========================================================================

	task automatic check_addr(input row_walk_pkg::gaddr_t got, input row_walk_pkg::gaddr_t exp);
		checks++;
		if (got !== exp) begin
			$display("FAILED o_row_linear row %0d: got %h expected %h", rows_seen, got, exp);
			errors++;
		end
	endtask

	task automatic check_pad(input row_walk_pkg::pad_t got, input row_walk_pkg::pad_t exp);
		checks++;
		if (got !== exp) begin
			$display("FAILED o_row_pad row %0d: got %h expected %h", rows_seen, got, exp);
			errors++;
		end
	endtask

	task automatic check_last(input bit got, input bit exp);
		checks++;
		if (got !== exp) begin
			$display("FAILED o_row_islast row %0d: got %h expected %h", rows_seen, got, exp);
			errors++;
		end
	endtask

	task automatic check_ack(input bit got, input bit exp);
		checks++;
		if (got !== exp) begin
			$display("FAILED o_cmd_ack after reset: got %h expected %h", got, exp);
			errors++;
		end
	endtask

	// Command j must be taken before command j-1 has left completely
	task automatic check_overlap(input int j);
		checks++;
		if (j > 0 && rows_seen >= cum_rows[j-1]) begin
			$display("Command %0d was accepted only after command %0d had finished", j, j - 1);
			errors++;
		end
	endtask

	task automatic take_row();
		if (exp_linear.size() == 0) begin
			$display("Row %0d arrived with no expected row left", rows_seen);
			errors++;
		end else begin
			check_addr(row_linear, exp_linear.pop_front());
			check_pad(row_pad, exp_pad.pop_front());
			check_last(row_islast, exp_last.pop_front());
		end
		run_len++;
		// Rows per command from the product of (end/stride + 1)
		if (row_islast) begin
			if (out_cmd < n_cmds && run_len != cmd_rows[out_cmd]) begin
				$display("FAILED row count of command %0d: got %h expected %h",
					out_cmd, run_len, cmd_rows[out_cmd]);
				errors++;
			end
			out_cmd++;
			run_len = 0;
		end
		rows_seen++;
	endtask

	task automatic print_counts();
		$display("Rows %0d of %0d, checks %0d, errors %0d", rows_seen, total_rows, checks, errors);
	endtask

	task automatic drive_cmd(input int k);
		cmd_rdy <= 1'b1;
		maddr <= tbl_maddr[k];
		for (int d = 0; d < tau_cfg_pkg::DIM; d++) begin
			mofs[d] <= tbl_mofs[k][d];
			mpad[d] <= tbl_mpad[k][d];
			mbound[d] <= tbl_mbound[k][d];
			mlast[d] <= tbl_mlast[k][d];
		end
	endtask

	//==========================================================================
	// Stimulus and monitors
	//==========================================================================

	// Random sink back-pressure, ack about 3 cycles in 4
	initial begin
		row_ack <= 1'b0;
		forever begin
			@(posedge clk);
			rand_val = $random(seed);
			row_ack <= (rand_val[1:0] != 2'b00);
		end
	end

	// Row transfers on the next rising edge
	always @(negedge clk) begin
		if (rst_n && row_rdy && row_ack)
			take_row();
	end

	initial begin
		cmd_rdy <= 1'b0;
		maddr <= '0;
		for (int d = 0; d < tau_cfg_pkg::DIM; d++) begin
			mofs[d] <= '0;
			mpad[d] <= '0;
			mbound[d] <= '0;
			mlast[d] <= '0;
		end
		// addr, ofs0, ofs1, pad1, pad2 / bnd0, bnd1, bnd2, last0, last1
		add_cmd(16'h1000, 16'h0000, 16'h0000, 3'h2, 3'h4,
			16'h0100, 16'h0040, 16'h0010, 16'h0080, 16'h0030);
		add_cmd(16'h2000, 16'hFFC0, 16'hFFF0, 3'h1, 3'h6,
			16'h0100, 16'h0040, 16'h0010, 16'h0040, 16'h0020);
		add_cmd(16'h0000, 16'h00C0, 16'h0020, 3'h5, 3'h3,
			16'h0100, 16'h0040, 16'h0010, 16'h0080, 16'h0030);
		add_cmd(16'h3000, 16'h0003, 16'h0002, 3'h4, 3'h1,
			16'h0020, 16'h0008, 16'h0004, 16'h0000, 16'h0000);
		add_cmd(16'h0400, 16'h0000, 16'hFFFC, 3'h2, 3'h0,
			16'h0020, 16'h0020, 16'h0004, 16'h0000, 16'h001C);
		add_cmd(16'h8000, 16'h0200, 16'h0000, 3'h2, 3'h7,
			16'h0400, 16'h0100, 16'h0040, 16'h0300, 16'h0000);
		add_cmd(16'h4000, 16'hFF00, 16'h0040, 3'h6, 3'h1,
			16'h0500, 16'h0100, 16'h0020, 16'h0400, 16'h0080);
		add_cmd(16'hFFF0, 16'h0000, 16'h0010, 3'h0, 3'h0,
			16'h0080, 16'h0020, 16'h0008, 16'h0040, 16'h0018);
		for (int k = 0; k < n_cmds; k++) begin
			cmd_rows[k] = (int'(tbl_mlast[k][0]) / int'(tbl_mbound[k][1]) + 1)
				* (int'(tbl_mlast[k][1]) / int'(tbl_mbound[k][2]) + 1);
			total_rows += cmd_rows[k];
			cum_rows[k] = total_rows;
			build_expected(k);
		end
		cycle_limit = 4 * total_rows + 200;
		@(posedge rst_n);
		// Ack stays low for the first cycle out of reset, then opens
		@(negedge clk);
		check_ack(cmd_ack, 1'b0);
		@(negedge clk);
		check_ack(cmd_ack, 1'b1);
		// Next command goes out on the edge that takes the previous one
		for (int k = 0; k < n_cmds; k++) begin
			@(posedge clk);
			if (k > 0)
				check_overlap(k - 1);
			drive_cmd(k);
			do @(negedge clk); while (!cmd_ack);
		end
		@(posedge clk);
		check_overlap(n_cmds - 1);
		cmd_rdy <= 1'b0;
		while (rows_seen < total_rows)
			@(negedge clk);
		// Nothing may follow the last row
		repeat (10) @(negedge clk);
		if (row_rdy) begin
			$display("A row was still offered after the last expected row");
			errors++;
		end
		print_counts();
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, not all rows were delivered", cycle_count);
		print_counts();
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- verification/tb_clk_gen.sv
//==========================================================================
// Clock and reset source for the testbench
// 8 ns clock, reset low for the first 8 rising edges
//==========================================================================

`timescale 1ns/10ps

module tb_clk_gen (
	output logic o_clk,
	output logic o_rst_n
);

	// Free running clock, half period 4 ns
	initial begin
		o_clk = 1'b0;
		forever #4 o_clk = ~o_clk;
	end

	// Release on a rising edge, same as the other drivers
	initial begin
		o_rst_n = 1'b0;
		repeat (8) @(posedge o_clk);
		o_rst_n <= 1'b1;
	end

endmodule

//--- verilog/chunk_row_start.sv
//==========================================================================
// Row start generator for one tensor chunk per command
// Two cycles from command accept to the first row without back pressure
// Then one row per cycle while the sink acks
//==========================================================================

`timescale 1ns/10ps

module chunk_row_start (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	// Command port
	input  logic                 i_cmd_rdy,
	output logic                 o_cmd_ack,
	input  row_walk_pkg::gaddr_t i_mofs   [tau_cfg_pkg::DIM],
	input  row_walk_pkg::pad_t   i_mpad   [tau_cfg_pkg::DIM],
	input  row_walk_pkg::gaddr_t i_mbound [tau_cfg_pkg::DIM],
	input  row_walk_pkg::gaddr_t i_mlast  [tau_cfg_pkg::DIM],
	input  row_walk_pkg::gaddr_t i_maddr,
	// Row port
	output logic                 o_row_rdy,
	input  logic                 i_row_ack,
	output row_walk_pkg::gaddr_t o_row_linear,
	output logic                 o_row_islast,
	output row_walk_pkg::pad_t   o_row_pad
);

	//==========================================================================
	// Stage links
	//==========================================================================

	// Decode to counter
	logic job_rdy, job_ack;
	row_walk_pkg::gaddr_t job_end    [tau_cfg_pkg::ROW_DIM];
	row_walk_pkg::gaddr_t job_stride [tau_cfg_pkg::ROW_DIM];

	// Job fields used by the result stage
	row_walk_pkg::gaddr_t job_mofs   [tau_cfg_pkg::DIM];
	row_walk_pkg::gaddr_t job_mbound [tau_cfg_pkg::DIM];
	row_walk_pkg::pad_t   job_mpad   [tau_cfg_pkg::DIM];
	row_walk_pkg::gaddr_t job_maddr;

	// Counter to result
	logic step_rdy, step_ack;
	row_walk_pkg::gaddr_t step_idx [tau_cfg_pkg::ROW_DIM];
	row_walk_pkg::dim_flags_t step_at_end;
	logic step_islast;

	//==========================================================================
	// Stages
	//==========================================================================

	row_cmd_decode row_cmd_decode_inst (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_cmd_rdy    (i_cmd_rdy),
		.o_cmd_ack    (o_cmd_ack),
		.i_mofs       (i_mofs),
		.i_mpad       (i_mpad),
		.i_mbound     (i_mbound),
		.i_mlast      (i_mlast),
		.i_maddr      (i_maddr),
		.o_job_rdy    (job_rdy),
		.i_job_ack    (job_ack),
		.o_job_end    (job_end),
		.o_job_stride (job_stride),
		.o_job_mofs   (job_mofs),
		.o_job_mbound (job_mbound),
		.o_job_mpad   (job_mpad),
		.o_job_maddr  (job_maddr)
	);

	// Job stays offered for the whole walk
	row_counter row_counter_inst (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_job_rdy     (job_rdy),
		.o_job_ack     (job_ack),
		.i_job_end     (job_end),
		.i_job_stride  (job_stride),
		.o_step_rdy    (step_rdy),
		.i_step_ack    (step_ack),
		.o_step_idx    (step_idx),
		.o_step_at_end (step_at_end),
		.o_step_islast (step_islast)
	);

	row_addr_clamp row_addr_clamp_inst (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_step_rdy    (step_rdy),
		.o_step_ack    (step_ack),
		.i_step_idx    (step_idx),
		.i_step_at_end (step_at_end),
		.i_step_islast (step_islast),
		.i_mofs        (job_mofs),
		.i_mbound      (job_mbound),
		.i_mpad        (job_mpad),
		.i_maddr       (job_maddr),
		.o_row_rdy     (o_row_rdy),
		.i_row_ack     (i_row_ack),
		.o_row_linear  (o_row_linear),
		.o_row_islast  (o_row_islast),
		.o_row_pad     (o_row_pad)
	);

endmodule

//--- verilog/row_cmd_decode.sv
//==========================================================================
// Two slot command buffer in front of the row walker
// The active slot stays on the job port until the walker acks it
// A second command is held and issued right after that ack
//==========================================================================

`timescale 1ns/10ps

module row_cmd_decode (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_cmd_rdy,
	output logic                 o_cmd_ack,
	input  row_walk_pkg::gaddr_t i_mofs       [tau_cfg_pkg::DIM],
	input  row_walk_pkg::pad_t   i_mpad       [tau_cfg_pkg::DIM],
	input  row_walk_pkg::gaddr_t i_mbound     [tau_cfg_pkg::DIM],
	input  row_walk_pkg::gaddr_t i_mlast      [tau_cfg_pkg::DIM],
	input  row_walk_pkg::gaddr_t i_maddr,
	output logic                 o_job_rdy,
	input  logic                 i_job_ack,
	output row_walk_pkg::gaddr_t o_job_end    [tau_cfg_pkg::ROW_DIM],
	output row_walk_pkg::gaddr_t o_job_stride [tau_cfg_pkg::ROW_DIM],
	output row_walk_pkg::gaddr_t o_job_mofs   [tau_cfg_pkg::DIM],
	output row_walk_pkg::gaddr_t o_job_mbound [tau_cfg_pkg::DIM],
	output row_walk_pkg::pad_t   o_job_mpad   [tau_cfg_pkg::DIM],
	output row_walk_pkg::gaddr_t o_job_maddr
);

	//==========================================================================
	// Internal signals
	//==========================================================================

	row_walk_pkg::decode_state_e state, state_nxt;
	logic init_done;
	logic cmd_xfer, job_xfer;
	logic act_from_cmd, act_from_hold, hold_load;

	// Row end and stride of the incoming command
	row_walk_pkg::gaddr_t cmd_end    [tau_cfg_pkg::ROW_DIM];
	row_walk_pkg::gaddr_t cmd_stride [tau_cfg_pkg::ROW_DIM];

	// Pending slot
	row_walk_pkg::gaddr_t hold_end    [tau_cfg_pkg::ROW_DIM];
	row_walk_pkg::gaddr_t hold_stride [tau_cfg_pkg::ROW_DIM];
	row_walk_pkg::gaddr_t hold_mofs   [tau_cfg_pkg::DIM];
	row_walk_pkg::gaddr_t hold_mbound [tau_cfg_pkg::DIM];
	row_walk_pkg::pad_t   hold_mpad   [tau_cfg_pkg::DIM];
	row_walk_pkg::gaddr_t hold_maddr;

	// Reshape
	// Walked dimension i ends at mlast[i] and steps by the next bound
	always_comb begin
		for (int i = 0; i < tau_cfg_pkg::ROW_DIM; i++) begin
			cmd_end[i] = i_mlast[i];
			cmd_stride[i] = i_mbound[i+1];
		end
	end

	// Ack opens one cycle after reset and closes while both slots are full
	assign o_cmd_ack = init_done && (state != row_walk_pkg::DEC_HOLD);
	assign o_job_rdy = (state != row_walk_pkg::DEC_IDLE);
	assign cmd_xfer = i_cmd_rdy && o_cmd_ack;
	assign job_xfer = o_job_rdy && i_job_ack;

	//==========================================================================
	// Slot control
	//==========================================================================

	always_comb begin
		state_nxt = state;
		act_from_cmd = 1'b0;
		act_from_hold = 1'b0;
		hold_load = 1'b0;
		case (state)
			row_walk_pkg::DEC_IDLE: begin
				if (cmd_xfer) begin
					act_from_cmd = 1'b1;
					state_nxt = row_walk_pkg::DEC_BUSY;
				end
			end
			row_walk_pkg::DEC_BUSY: begin
				// Release and new command together, new one goes straight to active
				if (cmd_xfer && job_xfer) begin
					act_from_cmd = 1'b1;
				end else if (cmd_xfer) begin
					hold_load = 1'b1;
					state_nxt = row_walk_pkg::DEC_HOLD;
				end else if (job_xfer) begin
					state_nxt = row_walk_pkg::DEC_IDLE;
				end
			end
			row_walk_pkg::DEC_HOLD: begin
				if (job_xfer) begin
					act_from_hold = 1'b1;
					state_nxt = row_walk_pkg::DEC_BUSY;
				end
			end
			default: state_nxt = row_walk_pkg::DEC_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= row_walk_pkg::DEC_IDLE;
			init_done <= 1'b0;
		end else begin
			state <= state_nxt;
			init_done <= 1'b1;
		end
	end

	//==========================================================================
	// Slot payload
	//==========================================================================

	always_ff @(posedge i_clk) begin
		if (hold_load) begin
			hold_end <= cmd_end;
			hold_stride <= cmd_stride;
			hold_mofs <= i_mofs;
			hold_mbound <= i_mbound;
			hold_mpad <= i_mpad;
			hold_maddr <= i_maddr;
		end
		// Active slot drives the job port directly
		if (act_from_cmd) begin
			o_job_end <= cmd_end;
			o_job_stride <= cmd_stride;
			o_job_mofs <= i_mofs;
			o_job_mbound <= i_mbound;
			o_job_mpad <= i_mpad;
			o_job_maddr <= i_maddr;
		end else if (act_from_hold) begin
			o_job_end <= hold_end;
			o_job_stride <= hold_stride;
			o_job_mofs <= hold_mofs;
			o_job_mbound <= hold_mbound;
			o_job_mpad <= hold_mpad;
			o_job_maddr <= hold_maddr;
		end
	end

endmodule
